//--- source/fetch_pkg.sv
// Shared types and constants for the barrel-threaded fetch front end
// Word, hart id, hart mask, hart run state, NOP encoding, PC step

`default_nettype none

package fetch_pkg;

    //////////////////////////////
    // Widths and counts
    //////////////////////////////

    localparam int HART_NUM = 4;               // Hardware threads sharing fetch
    localparam int WORD_W   = 32;              // Data word width
    localparam int HART_W   = 2;               // Hart index width

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [WORD_W-1:0]   word_t;       // Instruction, PC or address
    typedef logic [HART_W-1:0]   hart_id_t;    // Hart index
    typedef logic [HART_NUM-1:0] hart_mask_t;  // Bit n belongs to hart n

    // Per-hart run state
    typedef enum logic [1:0] {
        HART_IDLE   = 2'd0,                    // Not fetching
        HART_PEND   = 2'd1,                    // Start accepted, PC being seeded
        HART_ACTIVE = 2'd2                     // Eligible for issue
    } hart_state_e;

    //////////////////////////////
    // Constants
    //////////////////////////////

    // addi x0,x0,0
    localparam word_t OP_NOP  = 32'h0000_0013; // Filler for empty or squashed slots
    localparam word_t PC_STEP = 32'd4;         // One word per issued slot

endpackage

`default_nettype wire

//--- source/hart_ctrl.sv
// Hart control: per-hart run-state FSM, start and halt handling,
// PC seed strobe for the IF/ID register and the active mask

`timescale 1ns/1ps
`default_nettype none

module hart_ctrl (
    input  wire                   clk,          // Clock
    input  wire                   rst_n,        // Async reset, active low
    input  wire                   start,        // Start strobe
    input  wire fetch_pkg::hart_id_t start_id,  // Hart to start
    input  wire fetch_pkg::word_t    start_pc,  // Its first PC
    input  wire                   halt,         // Halt strobe
    input  wire fetch_pkg::hart_id_t halt_id,   // Hart to halt
    output fetch_pkg::hart_mask_t hart_active,  // Harts eligible for issue
    output logic                  pc_load,      // Seed a PC this cycle
    output fetch_pkg::hart_id_t   pc_load_id,   // Hart being seeded
    output fetch_pkg::word_t      pc_load_pc    // Seed value
);

    fetch_pkg::hart_state_e state_q [fetch_pkg::HART_NUM]; // Run state per hart
    logic                   start_ok;                      // Start hits an idle hart

    assign start_ok = start && (state_q[start_id] == fetch_pkg::HART_IDLE);

    //////////////////////////////
    // Run-state FSM, one per hart
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
                state_q[h] <= fetch_pkg::HART_IDLE;
            end
            pc_load <= 1'b0;
        end else begin
            for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
                case (state_q[h])
                    fetch_pkg::HART_IDLE: begin
                        if (start && start_id == fetch_pkg::hart_id_t'(h)) begin
                            state_q[h] <= fetch_pkg::HART_PEND;   // Seed PC next cycle
                        end
                    end
                    fetch_pkg::HART_PEND: begin
                        state_q[h] <= fetch_pkg::HART_ACTIVE;     // PC seeded by now
                    end
                    fetch_pkg::HART_ACTIVE: begin
                        if (halt && halt_id == fetch_pkg::hart_id_t'(h)) begin
                            state_q[h] <= fetch_pkg::HART_IDLE;
                        end
                    end
                    default: state_q[h] <= fetch_pkg::HART_IDLE;
                endcase
            end
            pc_load <= start_ok;                  // One-cycle seed strobe
        end
    end

    // Seed payload, only meaningful with pc_load
    always_ff @(posedge clk) begin
        if (start_ok) begin
            pc_load_id <= start_id;
            pc_load_pc <= start_pc;
        end
    end

    always_comb begin
        for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
            hart_active[h] = (state_q[h] == fetch_pkg::HART_ACTIVE);
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Seed lands while the hart is still pending, never on an issuing hart
    a_load_pend: assert property (@(posedge clk) disable iff (!rst_n)
        pc_load |-> (state_q[pc_load_id] == fetch_pkg::HART_PEND));

    a_start_halt: assert property (@(posedge clk) disable iff (!rst_n)
        !(start && halt && start_id == halt_id));

endmodule

`default_nettype wire

//--- source/hart_sched.sv
// Round-robin hart scheduler over the active mask

`timescale 1ns/1ps
`default_nettype none

module hart_sched (
    input  wire                         clk,         // Clock
    input  wire                         rst_n,       // Async reset, active low
    input  wire fetch_pkg::hart_mask_t  hart_active, // Eligible harts
    input  wire                         sched_adv,   // Selected hart was consumed
    output fetch_pkg::hart_id_t         sel_id,      // Hart to fetch for
    output logic                        sel_valid    // Some hart is eligible
);

    fetch_pkg::hart_id_t last_q;   // Last issued hart

    // Search starts just past the last issued hart
    always_comb begin : rr_pick
        fetch_pkg::hart_id_t cand;
        logic                found;
        sel_id = last_q;           // Don't care when nothing is active
        found  = 1'b0;
        for (int i = 1; i <= fetch_pkg::HART_NUM; i++) begin
            cand = fetch_pkg::hart_id_t'(int'(last_q) + i);   // Wraps in 2 bits
            if (!found && hart_active[cand]) begin
                sel_id = cand;
                found  = 1'b1;
            end
        end
    end

    assign sel_valid = |hart_active;

    // Pointer only moves on a consumed slot, so stall freezes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= fetch_pkg::hart_id_t'(fetch_pkg::HART_NUM - 1); // Hart 0 goes first
        end else if (sched_adv) begin
            last_q <= sel_id;
        end
    end

    // A consumed slot must have belonged to an active hart
    a_sel_active: assert property (@(posedge clk) disable iff (!rst_n)
        sched_adv |-> hart_active[sel_id]);

endmodule

`default_nettype wire

//--- source/insn_mem.sv
// Word-addressed instruction memory
// Clocked write port, asynchronous read port

`timescale 1ns/1ps
`default_nettype none

module insn_mem #(
    parameter int IMEM_AW = 8                      // Word address width
) (
    input  wire                      clk,          // Clock
    input  wire                      we,           // Write strobe
    input  wire [IMEM_AW-1:0]        waddr,        // Write word address
    input  wire fetch_pkg::word_t    wdata,        // Write data
    input  wire [IMEM_AW-1:0]        raddr,        // Fetch word address
    output fetch_pkg::word_t         rdata         // Fetched word
);

    localparam int DEPTH = 2 ** IMEM_AW;           // Words in the array

    fetch_pkg::word_t mem [DEPTH];                 // Contents come from the loader

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Same-cycle read so the IF/ID register can capture it at the edge
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

//--- source/if_reg.sv
// Per-hart PC file and IF/ID pipeline register
// Issue, branch redirect with squash, stall hold, PC seeding

`timescale 1ns/1ps
`default_nettype none

module if_reg #(
    parameter int IMEM_AW = 8                          // Word address width
) (
    input  wire                      clk,              // Clock
    input  wire                      rst_n,            // Async reset, active low
    input  wire                      stall,            // Freeze issue path
    input  wire fetch_pkg::hart_id_t sel_id,           // Scheduled hart
    input  wire                      sel_valid,        // Scheduled hart exists
    input  wire fetch_pkg::word_t    insn,             // Word at fetch_addr
    input  wire                      br_valid,         // Branch redirect strobe
    input  wire fetch_pkg::hart_id_t br_hart_id,       // Redirected hart
    input  wire fetch_pkg::word_t    br_addr,          // Branch target
    input  wire                      pc_load,          // PC seed strobe
    input  wire fetch_pkg::hart_id_t pc_load_id,       // Seeded hart
    input  wire fetch_pkg::word_t    pc_load_pc,       // Seed value
    output logic [IMEM_AW-1:0]       fetch_addr,       // Memory word address
    output logic                     sched_adv,        // Slot consumed
    output fetch_pkg::word_t         if_pc,            // PC of registered slot
    output fetch_pkg::word_t         if_insn,          // Instruction for decode
    output logic                     if_en,            // Slot carries a real insn
    output fetch_pkg::hart_id_t      if_hart_id        // Owner of the slot
);

    fetch_pkg::word_t pc_q [fetch_pkg::HART_NUM];      // One PC per hart
    fetch_pkg::word_t sel_pc;                          // PC of scheduled hart
    logic             take;                            // Slot consumed this cycle
    logic             squash;                          // Branch kills the slot

    //////////////////////////////
    // Fetch side
    //////////////////////////////

    assign sel_pc     = pc_q[sel_id];
    assign fetch_addr = sel_pc[IMEM_AW+1:2];           // Byte PC to word address
    assign take       = sel_valid && !stall;
    assign squash     = br_valid && (br_hart_id == sel_id);
    assign sched_adv  = take;                          // Issued or squashed alike

    //////////////////////////////
    // PC file
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
                pc_q[h] <= '0;
            end
        end else begin
            for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
                if (pc_load && pc_load_id == fetch_pkg::hart_id_t'(h)) begin
                    pc_q[h] <= pc_load_pc;                        // Seed, ignores stall
                end else if (!stall && br_valid &&
                             br_hart_id == fetch_pkg::hart_id_t'(h)) begin
                    pc_q[h] <= br_addr;                           // Redirect wins over step
                end else if (take && sel_id == fetch_pkg::hart_id_t'(h)) begin
                    pc_q[h] <= pc_q[h] + fetch_pkg::PC_STEP;      // Sequential fetch
                end
            end
        end
    end

    //////////////////////////////
    // IF/ID register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_pc      <= '0;
            if_insn    <= fetch_pkg::OP_NOP;
            if_en      <= 1'b0;
            if_hart_id <= '0;
        end else if (!stall) begin
            if (sel_valid) begin
                if_pc      <= sel_pc;
                if_hart_id <= sel_id;
                if (squash) begin
                    if_insn <= fetch_pkg::OP_NOP;                 // Killed by redirect
                    if_en   <= 1'b0;
                end else begin
                    if_insn <= insn;
                    if_en   <= 1'b1;
                end
            end else begin
                // Empty slot, owner and PC keep the last slot's values
                if_insn <= fetch_pkg::OP_NOP;
                if_en   <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_br_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(br_valid && stall));

    // A freshly loaded live slot carries exactly the word read in its fetch cycle
    a_issue_data: assert property (@(posedge clk) disable iff (!rst_n)
        (if_en && !$past(stall)) |-> (if_insn == $past(insn)));

endmodule

`default_nettype wire

//--- source/fetch_top.sv
// Fetch front end top: hart control, scheduler, instruction memory
// and IF/ID register

`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int IMEM_AW = 8                          // Memory word address width
) (
    input  wire                      clk,              // Clock
    input  wire                      rst_n,            // Async reset, active low
    input  wire                      stall,            // Issue hold
    input  wire                      br_valid,         // Branch redirect
    input  wire fetch_pkg::hart_id_t br_hart_id,
    input  wire fetch_pkg::word_t    br_addr,
    input  wire                      start,            // Hart start command
    input  wire fetch_pkg::hart_id_t start_id,
    input  wire fetch_pkg::word_t    start_pc,
    input  wire                      halt,             // Hart halt command
    input  wire fetch_pkg::hart_id_t halt_id,
    input  wire                      imem_we,          // Memory load port
    input  wire [IMEM_AW-1:0]        imem_waddr,
    input  wire fetch_pkg::word_t    imem_wdata,
    output fetch_pkg::word_t         if_insn,          // To decode
    output fetch_pkg::word_t         if_pc,
    output logic                     if_en,
    output fetch_pkg::hart_id_t      if_hart_id,
    output fetch_pkg::hart_mask_t    hart_active       // Run mask
);

    logic                pc_load;      // Seed strobe
    fetch_pkg::hart_id_t pc_load_id;
    fetch_pkg::word_t    pc_load_pc;
    fetch_pkg::hart_id_t sel_id;       // Scheduled hart
    logic                sel_valid;
    logic                sched_adv;    // Slot consumed
    logic [IMEM_AW-1:0]  fetch_addr;   // Memory read address
    fetch_pkg::word_t    insn;         // Memory read data

    hart_ctrl u_hart_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .start_id    (start_id),
        .start_pc    (start_pc),
        .halt        (halt),
        .halt_id     (halt_id),
        .hart_active (hart_active),
        .pc_load     (pc_load),
        .pc_load_id  (pc_load_id),
        .pc_load_pc  (pc_load_pc)
    );

    hart_sched u_hart_sched (
        .clk         (clk),
        .rst_n       (rst_n),
        .hart_active (hart_active),
        .sched_adv   (sched_adv),
        .sel_id      (sel_id),
        .sel_valid   (sel_valid)
    );

    insn_mem #(.IMEM_AW(IMEM_AW)) u_insn_mem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata),
        .raddr (fetch_addr),
        .rdata (insn)
    );

    if_reg #(.IMEM_AW(IMEM_AW)) u_if_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .sel_id     (sel_id),
        .sel_valid  (sel_valid),
        .insn       (insn),
        .br_valid   (br_valid),
        .br_hart_id (br_hart_id),
        .br_addr    (br_addr),
        .pc_load    (pc_load),
        .pc_load_id (pc_load_id),
        .pc_load_pc (pc_load_pc),
        .fetch_addr (fetch_addr),
        .sched_adv  (sched_adv),
        .if_pc      (if_pc),
        .if_insn    (if_insn),
        .if_en      (if_en),
        .if_hart_id (if_hart_id)
    );

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
// Testbench for the fetch front end: random stimulus, cycle model of
// hart control, scheduling and IF/ID register, field checks, watchdog

`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int IMEM_AW     = 8;                        // Memory word address width
    localparam int DEPTH       = 2 ** IMEM_AW;             // Words to preload
    localparam int N_CYCLES    = 2000;                     // Random cycles
    localparam int CLK_NS      = 40;                       // Clock period
    localparam int WATCHDOG_NS = (N_CYCLES + 300) * CLK_NS;

    logic                  clk;
    logic                  rst_n;
    logic                  stall;
    logic                  br_valid;
    fetch_pkg::hart_id_t   br_hart_id;
    fetch_pkg::word_t      br_addr;
    logic                  start;
    fetch_pkg::hart_id_t   start_id;
    fetch_pkg::word_t      start_pc;
    logic                  halt;
    fetch_pkg::hart_id_t   halt_id;
    logic                  imem_we;
    logic [IMEM_AW-1:0]    imem_waddr;
    fetch_pkg::word_t      imem_wdata;
    fetch_pkg::word_t      if_insn;
    fetch_pkg::word_t      if_pc;
    logic                  if_en;
    fetch_pkg::hart_id_t   if_hart_id;
    fetch_pkg::hart_mask_t hart_active;

    //////////////////////////////
    // Cycle model state
    //////////////////////////////

    fetch_pkg::word_t       mem_model [DEPTH];             // Mirror of memory contents
    fetch_pkg::hart_state_e m_state [fetch_pkg::HART_NUM]; // Run state per hart
    fetch_pkg::word_t       m_pc [fetch_pkg::HART_NUM];    // PC per hart
    fetch_pkg::hart_id_t    m_last;                        // Last issued hart
    logic                   m_load;                        // Seed pending for next edge
    fetch_pkg::hart_id_t    m_load_id;
    fetch_pkg::word_t       m_load_pc;
    logic                   exp_en;                        // Expected IF/ID contents
    fetch_pkg::word_t       exp_insn;
    fetch_pkg::word_t       exp_pc;
    fetch_pkg::hart_id_t    exp_hid;
    int                     errors;
    int                     checks;
    int                     issued;
    int                     squashed;
    int                     seed;

    fetch_top #(.IMEM_AW(IMEM_AW)) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .br_valid    (br_valid),
        .br_hart_id  (br_hart_id),
        .br_addr     (br_addr),
        .start       (start),
        .start_id    (start_id),
        .start_pc    (start_pc),
        .halt        (halt),
        .halt_id     (halt_id),
        .imem_we     (imem_we),
        .imem_waddr  (imem_waddr),
        .imem_wdata  (imem_wdata),
        .if_insn     (if_insn),
        .if_pc       (if_pc),
        .if_en       (if_en),
        .if_hart_id  (if_hart_id),
        .hart_active (hart_active)
    );

    always #(CLK_NS / 2) clk = ~clk;                       // 40 ns period

    task automatic clear_inputs();
        stall      = 1'b0;
        br_valid   = 1'b0;
        br_hart_id = '0;
        br_addr    = '0;
        start      = 1'b0;
        start_id   = '0;
        start_pc   = '0;
        halt       = 1'b0;
        halt_id    = '0;
        imem_we    = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
    endtask

    task automatic model_reset();
        for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
            m_state[h] = fetch_pkg::HART_IDLE;
            m_pc[h]    = '0;
        end
        m_last    = 2'd3;                                  // Hart 0 comes first
        m_load    = 1'b0;
        m_load_id = '0;
        m_load_pc = '0;
        exp_en    = 1'b0;
        exp_insn  = fetch_pkg::OP_NOP;
        exp_pc    = '0;
        exp_hid   = '0;
    endtask

    task automatic compare_field(input string name, input fetch_pkg::word_t got,
                                 input fetch_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        fetch_pkg::word_t mask;
        mask = '0;
        for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
            mask[h] = (m_state[h] == fetch_pkg::HART_ACTIVE);
        end
        compare_field("if_en", 32'(if_en), 32'(exp_en));
        compare_field("if_insn", if_insn, exp_insn);
        compare_field("if_pc", if_pc, exp_pc);
        compare_field("if_hart_id", 32'(if_hart_id), 32'(exp_hid));
        compare_field("hart_active", 32'(hart_active), mask);
    endtask

    //////////////////////////////
    // Next-edge prediction
    //////////////////////////////

    task automatic model_step();
        fetch_pkg::hart_state_e nstate [fetch_pkg::HART_NUM];
        fetch_pkg::word_t       npc [fetch_pkg::HART_NUM];
        fetch_pkg::word_t       word_addr;
        fetch_pkg::hart_id_t    sel;
        fetch_pkg::hart_id_t    hid;
        logic                   any;
        logic                   take;
        logic                   squash;
        any = 1'b0;
        sel = m_last;
        for (int i = 1; i <= fetch_pkg::HART_NUM; i++) begin
            hid = fetch_pkg::hart_id_t'((int'(m_last) + i) % fetch_pkg::HART_NUM);
            if (!any && m_state[hid] == fetch_pkg::HART_ACTIVE) begin
                sel = hid;                                 // First active after last issued
                any = 1'b1;
            end
        end
        take   = any && !stall;
        squash = br_valid && (br_hart_id == sel);
        if (take) begin
            exp_pc  = m_pc[sel];
            exp_hid = sel;
            if (squash) begin
                exp_en   = 1'b0;                           // Slot killed by redirect
                exp_insn = fetch_pkg::OP_NOP;
                squashed++;
            end else begin
                word_addr = m_pc[sel] >> 2;
                exp_en    = 1'b1;
                exp_insn  = mem_model[word_addr[IMEM_AW-1:0]];
                issued++;
            end
        end else if (!stall) begin
            exp_en   = 1'b0;                               // Empty slot, owner holds
            exp_insn = fetch_pkg::OP_NOP;
        end
        for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
            hid       = fetch_pkg::hart_id_t'(h);
            npc[h]    = m_pc[h];
            nstate[h] = m_state[h];
            if (m_load && m_load_id == hid) begin
                npc[h] = m_load_pc;
            end else if (!stall && br_valid && br_hart_id == hid) begin
                npc[h] = br_addr;
            end else if (take && sel == hid) begin
                npc[h] = m_pc[h] + 32'd4;
            end
            case (m_state[h])
                fetch_pkg::HART_IDLE:   if (start && start_id == hid) nstate[h] = fetch_pkg::HART_PEND;
                fetch_pkg::HART_PEND:   nstate[h] = fetch_pkg::HART_ACTIVE;
                fetch_pkg::HART_ACTIVE: if (halt && halt_id == hid) nstate[h] = fetch_pkg::HART_IDLE;
                default:                nstate[h] = fetch_pkg::HART_IDLE;
            endcase
        end
        m_load    = start && (m_state[start_id] == fetch_pkg::HART_IDLE);
        m_load_id = start_id;
        m_load_pc = start_pc;
        if (take) m_last = sel;
        for (int h = 0; h < fetch_pkg::HART_NUM; h++) begin
            m_state[h] = nstate[h];
            m_pc[h]    = npc[h];
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = $random(seed);
        a = $random(seed);
        b = $random(seed);
        clear_inputs();
        stall    = (r[2:0] == 3'd0);                       // About one in eight
        start    = (r[5:3] == 3'd0);
        start_id = r[11:10];
        start_pc = a & 32'hffff_fffc;
        halt     = (r[9:6] == 4'd0);
        halt_id  = r[13:12];
        if (start && halt && start_id == halt_id) halt = 1'b0;
        br_hart_id = r[18:17];
        br_addr    = b & 32'hffff_fffc;
        // Redirects only for running harts and never under stall
        br_valid   = (r[16:14] == 3'd0) && !stall &&
                     (m_state[br_hart_id] == fetch_pkg::HART_ACTIVE);
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1 check_outputs();
        #1;                                                // Back to drive point
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin : main_seq
        logic [31:0] w;
        clk    = 1'b0;
        rst_n  = 1'b0;
        errors = 0;
        checks = 0;
        issued = 0;
        squashed = 0;
        seed   = 32'h8d98;
        clear_inputs();
        model_reset();
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        check_outputs();                                   // Reset values
        for (int i = 0; i < DEPTH; i++) begin
            w = $random(seed);
            imem_we      = 1'b1;
            imem_waddr   = IMEM_AW'(i);
            imem_wdata   = w;
            mem_model[i] = w;
            model_step();
            next_edge();
        end
        clear_inputs();
        for (int c = 0; c < N_CYCLES; c++) begin
            drive_random();
            model_step();
            next_edge();
        end
        $display("Checks: %0d  Errors: %0d  Issued: %0d  Squashed: %0d",
                 checks, errors, issued, squashed);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/fetch_pkg.sv
source/hart_ctrl.sv
source/hart_sched.sv
source/insn_mem.sv
source/if_reg.sv
source/fetch_top.sv
testbench/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fetch_tb_sim
LOG=sim.log

verilator --binary --timing --assert \
    --top-module fetch_tb \
    -f flist.f \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail, see $LOG"
    exit 1
fi
